//--- src/fe_params.svh
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// Virtual address width of the fetch PC
`define FE_VADDR_WIDTH 16

// Instruction word width
`define FE_INSTR_WIDTH 32

// Byte offset bits inside one instruction word
`define FE_WORD_OFFSET_WIDTH 2

// Instruction memory depth in words
`define FE_IMEM_WORDS 64

// Word index width into the instruction memory
`define FE_IMEM_IDX_WIDTH 6

`endif

//--- src/fe_pkg.sv
`include "fe_params.svh"

package fe_pkg;

  // Back end to front end command opcodes
  typedef enum logic
  {
    e_op_pc_redirect = 1'b0,
    e_op_wait        = 1'b1
  } fe_opcode_e;

  typedef struct packed
  {
    fe_opcode_e                 opcode;
    logic [`FE_VADDR_WIDTH-1:0] vaddr;
  } fe_cmd_s;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  typedef enum logic [1:0]
  {
    e_exc_none         = 2'd0,
    e_exc_misaligned   = 2'd1,
    e_exc_access_fault = 2'd2
  } fe_exc_code_e;

  // Fetch queue message, instr is zero for an exception
  typedef struct packed
  {
    fe_msg_type_e               msg_type;
    logic [`FE_VADDR_WIDTH-1:0] pc;
    logic [`FE_INSTR_WIDTH-1:0] instr;
    fe_exc_code_e               exc_code;
  } fe_queue_s;

  typedef struct packed
  {
    logic [`FE_IMEM_IDX_WIDTH-1:0] idx;
    logic [`FE_INSTR_WIDTH-1:0]    data;
  } fe_fill_s;

  // Payload carried from IF1 into IF2
  typedef struct packed
  {
    logic [`FE_VADDR_WIDTH-1:0] pc;
    logic [`FE_INSTR_WIDTH-1:0] instr;
    fe_exc_code_e               exc_code;
  } fe_if2_s;

endpackage

//--- src/fe_pc_gen.sv
`timescale 1ns/1ps

`include "fe_params.svh"

module fe_pc_gen
  (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  fe_pkg::fe_cmd_s            fe_cmd_i,
    input  logic                       fe_cmd_v_i,
    output logic                       fe_cmd_yumi_o,

    input  logic                       fe_queue_ready_i,

    input  logic                       fetch_fail_i,
    input  logic                       exc_sent_i,
    input  logic [`FE_VADDR_WIDTH-1:0] if2_pc_i,

    output logic                       fetch_v_o,
    output logic [`FE_VADDR_WIDTH-1:0] fetch_pc_o,
    output logic                       flush_o
  );

  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } state_e;

  state_e                     state_r;
  state_e                     state_n;
  logic                       cmd_accept;
  logic                       redirect_v;
  logic                       wait_v;
  logic [`FE_VADDR_WIDTH-1:0] pc_r;
  logic [`FE_VADDR_WIDTH-1:0] pc_resume_r;

  // Commands are taken as soon as they show up
  assign fe_cmd_yumi_o = fe_cmd_v_i & ~reset_i;
  assign cmd_accept    = fe_cmd_v_i & fe_cmd_yumi_o;

  assign redirect_v = cmd_accept & (fe_cmd_i.opcode == fe_pkg::e_op_pc_redirect);
  assign wait_v     = cmd_accept & (fe_cmd_i.opcode == fe_pkg::e_op_wait);

  // Any accepted command squashes whatever sits in IF1 and IF2
  assign flush_o = cmd_accept;

  always_comb
  begin
    state_n = state_r;
    if (redirect_v)
      state_n = e_run;
    else if (wait_v)
      state_n = e_wait;
    else
    begin
      case (state_r)
        e_run:
        begin
          // Replay from the blocked entry
          if (fetch_fail_i)
            state_n = e_stall;
          else if (exc_sent_i)
            state_n = e_wait;
        end
        e_stall:
        begin
          if (fe_queue_ready_i)
            state_n = e_run;
        end
        default:
          state_n = state_r;
      endcase
    end
  end

  // Redirect target goes out in the same cycle it is accepted
  always_comb
  begin
    if (redirect_v)
      fetch_pc_o = fe_cmd_i.vaddr;
    else if (state_r == e_stall)
      fetch_pc_o = pc_resume_r;
    else
      fetch_pc_o = pc_r;
  end

  assign fetch_v_o = (state_n == e_run);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_wait;
    else
      state_r <= state_n;
  end

  // Sequential PC, one word per issued fetch
  always_ff @(posedge clk_i)
  begin
    if (fetch_v_o)
      pc_r <= fetch_pc_o + `FE_VADDR_WIDTH'(4);
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_fail_i & ~cmd_accept)
      pc_resume_r <= if2_pc_i;
  end

endmodule

//--- src/fe_imem.sv
`timescale 1ns/1ps

`include "fe_params.svh"

module fe_imem
  (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  fe_pkg::fe_fill_s           imem_fill_i,
    input  logic                       imem_fill_v_i,

    input  logic                       fetch_v_i,
    input  logic [`FE_VADDR_WIDTH-1:0] fetch_pc_i,
    input  logic                       flush_i,

    output logic                       if2_v_o,
    output fe_pkg::fe_if2_s            if2_data_o
  );

  logic [`FE_INSTR_WIDTH-1:0] mem_r [`FE_IMEM_WORDS];

  logic [`FE_VADDR_WIDTH-`FE_WORD_OFFSET_WIDTH-1:0] word_idx;
  logic [`FE_IMEM_IDX_WIDTH-1:0]                    mem_idx;
  logic                                             misaligned;
  logic                                             out_of_range;
  fe_pkg::fe_exc_code_e                             exc_code;

  logic            if1_v_r;
  fe_pkg::fe_if2_s if1_r;

  assign word_idx = fetch_pc_i[`FE_VADDR_WIDTH-1:`FE_WORD_OFFSET_WIDTH];
  assign mem_idx  = word_idx[`FE_IMEM_IDX_WIDTH-1:0];

  assign misaligned   = |fetch_pc_i[`FE_WORD_OFFSET_WIDTH-1:0];
  assign out_of_range = (word_idx >= `FE_IMEM_WORDS);

  // Misaligned wins over access fault
  always_comb
  begin
    if (misaligned)
      exc_code = fe_pkg::e_exc_misaligned;
    else if (out_of_range)
      exc_code = fe_pkg::e_exc_access_fault;
    else
      exc_code = fe_pkg::e_exc_none;
  end

  always_ff @(posedge clk_i)
  begin
    if (imem_fill_v_i)
      mem_r[imem_fill_i.idx] <= imem_fill_i.data;
  end

  // Synchronous read, word and PC registered together
  always_ff @(posedge clk_i)
  begin
    if (fetch_v_i)
    begin
      if1_r.pc       <= fetch_pc_i;
      if1_r.instr    <= mem_r[mem_idx];
      if1_r.exc_code <= exc_code;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      if1_v_r <= 1'b0;
    else
      if1_v_r <= fetch_v_i;
  end

  // A flush kills the word held here
  // The redirect fetch of that cycle still enters behind it
  assign if2_v_o    = if1_v_r & ~flush_i;
  assign if2_data_o = if1_r;

endmodule

//--- src/fe_fetch_out.sv
`timescale 1ns/1ps

`include "fe_params.svh"

module fe_fetch_out
  (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  logic                       if2_v_i,
    input  fe_pkg::fe_if2_s            if2_data_i,
    input  logic                       flush_i,

    output fe_pkg::fe_queue_s          fe_queue_o,
    output logic                       fe_queue_v_o,
    input  logic                       fe_queue_ready_i,

    output logic                       fetch_fail_o,
    output logic                       exc_sent_o,
    output logic [`FE_VADDR_WIDTH-1:0] if2_pc_o
  );

  logic            if2_v_r;
  fe_pkg::fe_if2_s if2_r;
  logic            is_exc;
  logic            if2_v_n;

  assign is_exc = (if2_r.exc_code != fe_pkg::e_exc_none);

  // Offer only when the queue already has room and no command is landing
  assign fe_queue_v_o = if2_v_r & fe_queue_ready_i & ~flush_i;

  always_comb
  begin
    fe_queue_o.pc       = if2_r.pc;
    fe_queue_o.exc_code = if2_r.exc_code;
    if (is_exc)
    begin
      fe_queue_o.msg_type = fe_pkg::e_fe_exception;
      fe_queue_o.instr    = '0;
    end
    else
    begin
      fe_queue_o.msg_type = fe_pkg::e_fe_fetch;
      fe_queue_o.instr    = if2_r.instr;
    end
  end

  // Results handed back to IF0
  assign fetch_fail_o = if2_v_r & ~fe_queue_v_o;
  assign exc_sent_o   = fe_queue_v_o & is_exc;
  assign if2_pc_o     = if2_r.pc;

  // The younger IF1 word is dropped on a replay or after an exception
  assign if2_v_n = if2_v_i & ~flush_i & ~fetch_fail_o & ~exc_sent_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      if2_v_r <= 1'b0;
    else
      if2_v_r <= if2_v_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (if2_v_i)
      if2_r <= if2_data_i;
  end

endmodule

//--- src/fe_top.sv
`timescale 1ns/1ps

`include "fe_params.svh"

module fe_top
  (
    input  logic              clk_i,
    input  logic              reset_i,

    input  fe_pkg::fe_cmd_s   fe_cmd_i,
    input  logic              fe_cmd_v_i,
    output logic              fe_cmd_yumi_o,

    output fe_pkg::fe_queue_s fe_queue_o,
    output logic              fe_queue_v_o,
    input  logic              fe_queue_ready_i,

    input  fe_pkg::fe_fill_s  imem_fill_i,
    input  logic              imem_fill_v_i
  );

  // IF0 to IF1
  logic                       fetch_v;
  logic [`FE_VADDR_WIDTH-1:0] fetch_pc;
  logic                       flush;

  // IF1 to IF2
  logic                       if2_v;
  fe_pkg::fe_if2_s            if2_data;

  // IF2 back to IF0
  logic                       fetch_fail;
  logic                       exc_sent;
  logic [`FE_VADDR_WIDTH-1:0] if2_pc;

  fe_pc_gen pc_gen0
    (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .fe_cmd_i         (fe_cmd_i),
      .fe_cmd_v_i       (fe_cmd_v_i),
      .fe_cmd_yumi_o    (fe_cmd_yumi_o),
      .fe_queue_ready_i (fe_queue_ready_i),
      .fetch_fail_i     (fetch_fail),
      .exc_sent_i       (exc_sent),
      .if2_pc_i         (if2_pc),
      .fetch_v_o        (fetch_v),
      .fetch_pc_o       (fetch_pc),
      .flush_o          (flush)
    );

  fe_imem imem0
    (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .imem_fill_i   (imem_fill_i),
      .imem_fill_v_i (imem_fill_v_i),
      .fetch_v_i     (fetch_v),
      .fetch_pc_i    (fetch_pc),
      .flush_i       (flush),
      .if2_v_o       (if2_v),
      .if2_data_o    (if2_data)
    );

  fe_fetch_out fetch_out0
    (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .if2_v_i          (if2_v),
      .if2_data_i       (if2_data),
      .flush_i          (flush),
      .fe_queue_o       (fe_queue_o),
      .fe_queue_v_o     (fe_queue_v_o),
      .fe_queue_ready_i (fe_queue_ready_i),
      .fetch_fail_o     (fetch_fail),
      .exc_sent_o       (exc_sent),
      .if2_pc_o         (if2_pc)
    );

endmodule

//--- test/fe_tb_properties.sv
`timescale 1ns/1ps

`include "fe_params.svh"

module fe_tb_properties
  (
    input logic              clk_i,
    input logic              reset_i,
    input logic              fe_cmd_v_i,
    input logic              fe_cmd_yumi_o,
    input fe_pkg::fe_queue_s fe_queue_o,
    input logic              fe_queue_v_o,
    input logic              fe_queue_ready_i
  );

  int                         fail_count = 0;
  logic                       transfer;
  logic                       prev_fetch_v_r;
  logic [`FE_VADDR_WIDTH-1:0] prev_pc_r;

  assign transfer = fe_queue_v_o & fe_queue_ready_i;

  // Last fetch message of the current stream
  always_ff @(posedge clk_i)
  begin
    if (reset_i | (fe_cmd_v_i & fe_cmd_yumi_o))
      prev_fetch_v_r <= 1'b0;
    else if (transfer)
      prev_fetch_v_r <= (fe_queue_o.msg_type == fe_pkg::e_fe_fetch);
  end

  always_ff @(posedge clk_i)
  begin
    if (transfer)
      prev_pc_r <= fe_queue_o.pc;
  end

  queue_valid_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_queue_v_o |-> fe_queue_ready_i)
  else
  begin
    fail_count++;
    $error("queue valid raised while ready is low");
  end

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_cmd_yumi_o |-> fe_cmd_v_i)
  else
  begin
    fail_count++;
    $error("command yumi raised without a valid command");
  end

  quiet_after_reset: assert property (@(posedge clk_i) reset_i |=> !fe_queue_v_o)
  else
  begin
    fail_count++;
    $error("queue valid raised in the cycle after reset");
  end

  fetch_pc_step: assert property (@(posedge clk_i) disable iff (reset_i)
    (transfer && fe_queue_o.msg_type == fe_pkg::e_fe_fetch && prev_fetch_v_r)
      |-> (fe_queue_o.pc == prev_pc_r + `FE_VADDR_WIDTH'(4)))
  else
  begin
    fail_count++;
    $error("consecutive fetch messages do not step the pc by 4");
  end

endmodule

bind fe_top fe_tb_properties props0 (.*);

//--- test/fe_tb.sv
`timescale 1ns/1ps

`include "fe_params.svh"

module fe_tb;

  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 + 150 + 400 + 60 + 80 + 200;

  logic              clk_i;
  logic              reset_i;
  fe_pkg::fe_cmd_s   fe_cmd_i;
  logic              fe_cmd_v_i;
  logic              fe_cmd_yumi_o;
  fe_pkg::fe_queue_s fe_queue_o;
  logic              fe_queue_v_o;
  logic              fe_queue_ready_i;
  fe_pkg::fe_fill_s  imem_fill_i;
  logic              imem_fill_v_i;

  logic [`FE_INSTR_WIDTH-1:0] shadow_mem [`FE_IMEM_WORDS];
  logic [15:0]                lfsr_state = 16'd23620;

  int    cycle_count = 0;
  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    test_errors_start = 0;
  int    total_msgs = 0;
  int    msg_count = 0;
  int    exc_count = 0;
  int    accept_cycle = 0;
  int    first_msg_cycle = 0;
  string test_name = "reset";

  // Expected stream state
  logic                       exp_active = 1'b0;
  logic [`FE_VADDR_WIDTH-1:0] exp_pc = '0;
  fe_pkg::fe_queue_s          exp_msg;

  fe_top dut0 (.*);

  initial
  begin
    clk_i = 1'b0;
    forever
      #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cycle_count <= cycle_count + 1;

  // 16 bit Fibonacci LFSR, one step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    logic        fb;
    int          i;
    value = '0;
    for (i = 0; i < n; i++)
    begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic fe_pkg::fe_queue_s expected_msg(input logic [`FE_VADDR_WIDTH-1:0] pc);
    fe_pkg::fe_queue_s msg;
    msg.msg_type = fe_pkg::e_fe_exception;
    msg.pc       = pc;
    msg.instr    = '0;
    if (pc % 4 != 0)
      msg.exc_code = fe_pkg::e_exc_misaligned;
    else if (pc / 4 >= `FE_IMEM_WORDS)
      msg.exc_code = fe_pkg::e_exc_access_fault;
    else
    begin
      msg.msg_type = fe_pkg::e_fe_fetch;
      msg.instr    = shadow_mem[pc / 4];
      msg.exc_code = fe_pkg::e_exc_none;
    end
    return msg;
  endfunction

  // Checks every transfer, then follows accepted commands
  always @(posedge clk_i)
  begin
    if (!reset_i && fe_queue_v_o && fe_queue_ready_i)
    begin
      total_msgs++;
      assert (exp_active)
      else
      begin
        $display("Message at pc %h arrived while none was expected in %s",
                 fe_queue_o.pc, test_name);
        errors++;
      end
      if (exp_active)
      begin
        exp_msg = expected_msg(exp_pc);
        assert (fe_queue_o == exp_msg)
        else
        begin
          $display("CHECK FAILED %s: message expected %h actual %h",
                   test_name, exp_msg, fe_queue_o);
          errors++;
        end
        if (msg_count == 0)
          first_msg_cycle = cycle_count;
        msg_count++;
        if (exp_msg.msg_type == fe_pkg::e_fe_fetch)
          exp_pc = exp_pc + `FE_VADDR_WIDTH'(4);
        else
        begin
          exc_count++;
          exp_active = 1'b0;
        end
      end
    end
    if (!reset_i && fe_cmd_v_i && fe_cmd_yumi_o)
    begin
      msg_count    = 0;
      exc_count    = 0;
      accept_cycle = cycle_count;
      exp_active   = (fe_cmd_i.opcode == fe_pkg::e_op_pc_redirect);
      exp_pc       = fe_cmd_i.vaddr;
    end
  end

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual)
    else
    begin
      $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name         = name;
    test_errors_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_errors_start)
      $display("%s: passed", test_name);
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, errors - test_errors_start);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic wait_msgs(input int n);
    while (msg_count < n)
      @(negedge clk_i);
  endtask

  task automatic wait_excs(input int n);
    while (exc_count < n)
      @(negedge clk_i);
  endtask

  task automatic send_cmd(input fe_pkg::fe_opcode_e opcode, input logic [15:0] vaddr);
    fe_cmd_i.opcode = opcode;
    fe_cmd_i.vaddr  = vaddr;
    fe_cmd_v_i      = 1'b1;
    @(posedge clk_i);
    while (!fe_cmd_yumi_o)
      @(posedge clk_i);
    @(negedge clk_i);
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic fill_memory();
    logic [`FE_INSTR_WIDTH-1:0] word;
    int                         idx;
    for (idx = 0; idx < `FE_IMEM_WORDS; idx++)
    begin
      word             = random_bits(32);
      imem_fill_i.idx  = idx[`FE_IMEM_IDX_WIDTH-1:0];
      imem_fill_i.data = word;
      imem_fill_v_i    = 1'b1;
      shadow_mem[idx]  = word;
      @(negedge clk_i);
    end
    imem_fill_v_i = 1'b0;
  endtask

  initial
  begin
    reset_i          = 1'b1;
    fe_cmd_i         = '0;
    fe_cmd_v_i       = 1'b0;
    fe_queue_ready_i = 1'b1;
    imem_fill_i      = '0;
    imem_fill_v_i    = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;

    start_test("reset_quiet");
    idle(20);
    check_value("messages after reset", 0, total_msgs);
    end_test();

    start_test("straight_fetch");
    fill_memory();
    send_cmd(fe_pkg::e_op_pc_redirect, 16'd0);
    wait_excs(1);
    idle(10);
    check_value("messages up to the fault", `FE_IMEM_WORDS + 1, msg_count);
    check_value("first message latency", 2, first_msg_cycle - accept_cycle);
    end_test();

    start_test("back_pressure");
    send_cmd(fe_pkg::e_op_pc_redirect, 16'd8);
    while (msg_count < 30)
    begin
      @(negedge clk_i);
      fe_queue_ready_i = (random_bits(1) != 32'd0);
    end
    fe_queue_ready_i = 1'b1;
    end_test();

    start_test("redirect_mid_stream");
    send_cmd(fe_pkg::e_op_pc_redirect, 16'd0);
    wait_msgs(5);
    send_cmd(fe_pkg::e_op_pc_redirect, 16'd40);
    wait_msgs(10);
    end_test();

    start_test("exceptions_and_wait");
    send_cmd(fe_pkg::e_op_pc_redirect, 16'd6);
    wait_excs(1);
    idle(5);
    check_value("messages after misaligned pc", 1, msg_count);
    send_cmd(fe_pkg::e_op_pc_redirect, 16'd256);
    wait_excs(1);
    idle(5);
    check_value("messages after out of range pc", 1, msg_count);
    send_cmd(fe_pkg::e_op_pc_redirect, 16'd0);
    wait_msgs(3);
    send_cmd(fe_pkg::e_op_wait, 16'd0);
    idle(20);
    check_value("messages after wait", 0, msg_count);
    end_test();

    errors = errors + dut0.props0.fail_count;
    $display("Tests run %0d, tests failed %0d, assertion failures %0d, errors %0d",
             tests_run, tests_failed, dut0.props0.fail_count, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
      @(posedge clk_i);
    $display("Timeout after %0d cycles, the expected messages never arrived", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- files.f
+incdir+src
src/fe_pkg.sv
src/fe_pc_gen.sv
src/fe_imem.sv
src/fe_fetch_out.sv
src/fe_top.sv
test/fe_tb_properties.sv
test/fe_tb.sv
